/* sources.f */
hw/bus_pkg.sv
hw/pet_reg_pkg.sv
hw/register_file.sv
hw/cpu_control.sv
hw/video_address.sv
hw/pet_system_ctrl.sv
sim/clock_gen.sv
sim/pet_system_ctrl_properties.sv
sim/pet_system_ctrl_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator and run it; exit status follows the run
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing -j 0 \
    --top-module pet_system_ctrl_tb \
    -Mdir obj_dir \
    -f sources.f

# Keep running past an assertion so the testbench can report it
./obj_dir/Vpet_system_ctrl_tb +verilator+error+limit+100

/* sim/pet_system_ctrl_tb.sv */
// Testbench for the control block with bus tasks, reference model, checks and timeout
`timescale 1ns/100ps
`default_nettype none

module pet_system_ctrl_tb
    import bus_pkg::*;
    import pet_reg_pkg::*;
();

    localparam int          RESET_HOLD_CYCLES = 16;
    localparam int unsigned TIMEOUT_CYCLES    = 20000;
    localparam wb_addr_t    SPARE_ADDR        = 2'd3;

    logic        clock;
    logic        reset_n;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    wb_addr_t    wb_adr_i;
    wb_data_t    wb_dat_i;
    wb_data_t    wb_dat_o;
    logic        wb_ack_o;
    logic        wb_stall_o;
    logic        video_graphic_i;
    logic        config_crt_i;
    logic        config_keyboard_i;
    logic        cpu_reset_o;
    logic        cpu_ready_o;
    logic        cpu_nmi_o;
    logic        video_char_i;
    logic        video_frame_i;
    video_addr_t video_addr_o;

    // Video counter model state
    video_addr_t model_count;
    logic        model_col80;
    logic [1:0]  model_mask;
    int unsigned cycle_count;

    clock_gen i_clock_gen (
        .clock_o   (clock),
        .reset_n_o (reset_n)
    );

    pet_system_ctrl #(
        .RESET_HOLD_CYCLES (RESET_HOLD_CYCLES)
    ) i_pet_system_ctrl (
        .clock             (clock),
        .reset_n           (reset_n),
        .wb_cyc_i          (wb_cyc_i),
        .wb_stb_i          (wb_stb_i),
        .wb_we_i           (wb_we_i),
        .wb_adr_i          (wb_adr_i),
        .wb_dat_i          (wb_dat_i),
        .wb_dat_o          (wb_dat_o),
        .wb_ack_o          (wb_ack_o),
        .wb_stall_o        (wb_stall_o),
        .video_graphic_i   (video_graphic_i),
        .config_crt_i      (config_crt_i),
        .config_keyboard_i (config_keyboard_i),
        .cpu_reset_o       (cpu_reset_o),
        .cpu_ready_o       (cpu_ready_o),
        .cpu_nmi_o         (cpu_nmi_o),
        .video_char_i      (video_char_i),
        .video_frame_i     (video_frame_i),
        .video_addr_o      (video_addr_o)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual == expected) else begin
            $display("ERR t=%0t %s expected=%0h actual=%0h", $time, name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        check_value(name, 32'(expected), 32'(actual));
    endtask

    // CPU register image from its named bits
    function automatic wb_data_t cpu_value(input logic ready, input logic rst, input logic nmi);
        wb_data_t value;
        value                    = '0;
        value[REG_CPU_READY_BIT] = ready;
        value[REG_CPU_RESET_BIT] = rst;
        value[REG_CPU_NMI_BIT]   = nmi;
        return value;
    endfunction

    // Video register image from mode and mask
    function automatic wb_data_t video_value(input logic col80, input logic [1:0] mask);
        wb_data_t value;
        value                           = '0;
        value[REG_VIDEO_COL80_BIT]      = col80;
        value[REG_VIDEO_MASK_LSB +: 2]  = mask;
        return value;
    endfunction

    // Next cell per mode with a wrap after the last cell of 25 lines
    function automatic video_addr_t next_cell(input video_addr_t count, input logic col80);
        int last;
        last = SCREEN_ROWS * (col80 ? COLS_80 : COLS_40) - 1;
        if (int'(count) >= last) begin
            return '0;
        end
        return count + 1'b1;
    endfunction

    // Address bits 11 and 10 cleared where the RAM mask bit is low
    function automatic video_addr_t masked_address(input video_addr_t count,
                                                   input logic [1:0] mask);
        video_addr_t value;
        value = count;
        if (!mask[1]) begin
            value[11] = 1'b0;
        end
        if (!mask[0]) begin
            value[10] = 1'b0;
        end
        return value;
    endfunction

    // Strobe at a falling edge and hold cycle high until ack
    task automatic bus_cycle(input logic write, input wb_addr_t addr, input wb_data_t data);
        @(negedge clock);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = write;
        wb_adr_i = addr;
        wb_dat_i = data;
        @(negedge clock);
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        while (!wb_ack_o) begin
            @(negedge clock);
        end
        wb_cyc_i = 1'b0;
    endtask

    task automatic bus_write(input wb_addr_t addr, input wb_data_t data);
        bus_cycle(1'b1, addr, data);
        if (addr == REG_VIDEO) begin
            model_col80 = data[REG_VIDEO_COL80_BIT];
            model_mask  = data[REG_VIDEO_MASK_LSB +: 2];
        end
    endtask

    // Data valid at the ack edge
    task automatic bus_read(input wb_addr_t addr, output wb_data_t data);
        bus_cycle(1'b0, addr, '0);
        data = wb_dat_o;
    endtask

    task automatic power_on_check();
        wb_data_t data;
        @(negedge clock);
        check_bit("cpu_reset_o", 1'b1, cpu_reset_o);
        check_bit("cpu_ready_o", 1'b0, cpu_ready_o);
        check_bit("cpu_nmi_o", 1'b0, cpu_nmi_o);
        check_value("video_addr_o", 32'd0, 32'(video_addr_o));
        bus_read(REG_CPU, data);
        check_value("wb_dat_o cpu", 32'(cpu_value(1'b0, 1'b1, 1'b0)), 32'(data));
        bus_read(REG_VIDEO, data);
        check_value("wb_dat_o video", 32'(video_value(1'b0, 2'b11)), 32'(data));
    endtask

    // Random bytes read back through the defined bits only
    task automatic register_check();
        wb_data_t data;
        wb_data_t read;
        wb_data_t expected;
        int       round;
        for (round = 0; round < 4; round++) begin
            data = wb_data_t'($urandom);
            bus_write(REG_CPU, data);
            bus_read(REG_CPU, read);
            expected = data & cpu_value(1'b1, 1'b1, 1'b1);
            check_value("wb_dat_o cpu", 32'(expected), 32'(read));
            data = wb_data_t'($urandom);
            bus_write(REG_VIDEO, data);
            bus_read(REG_VIDEO, read);
            expected = data & video_value(1'b1, 2'b11);
            check_value("wb_dat_o video", 32'(expected), 32'(read));
            bus_write(SPARE_ADDR, wb_data_t'($urandom));
            bus_read(SPARE_ADDR, read);
            check_value("wb_dat_o spare", 32'd0, 32'(read));
        end
    endtask

    task automatic reset_stretch_check();
        int i;
        bus_write(REG_CPU, cpu_value(1'b1, 1'b1, 1'b0));
        check_bit("cpu_ready_o", 1'b0, cpu_ready_o);
        // Returns in the first cycle after the reset bit clears
        bus_write(REG_CPU, cpu_value(1'b1, 1'b0, 1'b0));
        for (i = 0; i < RESET_HOLD_CYCLES; i++) begin
            check_bit("cpu_reset_o", 1'b1, cpu_reset_o);
            check_bit("cpu_ready_o", 1'b0, cpu_ready_o);
            @(negedge clock);
        end
        check_bit("cpu_reset_o", 1'b0, cpu_reset_o);
        check_bit("cpu_ready_o", 1'b1, cpu_ready_o);
    endtask

    task automatic nmi_check();
        int i;
        bus_write(REG_CPU, cpu_value(1'b1, 1'b0, 1'b1));
        check_bit("cpu_nmi_o", 1'b1, cpu_nmi_o);
        for (i = 0; i < 3; i++) begin
            @(negedge clock);
            check_bit("cpu_nmi_o", 1'b0, cpu_nmi_o);
        end
        // No new pulse with the bit already set
        bus_write(REG_CPU, cpu_value(1'b1, 1'b0, 1'b1));
        for (i = 0; i < 3; i++) begin
            check_bit("cpu_nmi_o", 1'b0, cpu_nmi_o);
            @(negedge clock);
        end
        bus_write(REG_CPU, cpu_value(1'b1, 1'b0, 1'b0));
    endtask

    task automatic status_check(input logic [2:0] pattern);
        wb_data_t expected;
        wb_data_t read;
        @(negedge clock);
        video_graphic_i   = pattern[0];
        config_crt_i      = pattern[1];
        config_keyboard_i = pattern[2];
        repeat (2) @(negedge clock);
        expected                          = '0;
        expected[REG_STATUS_GRAPHICS_BIT] = pattern[0];
        expected[REG_STATUS_CRT_BIT]      = pattern[1];
        expected[REG_STATUS_KEYBOARD_BIT] = pattern[2];
        bus_read(REG_STATUS, read);
        check_value("wb_dat_o status", 32'(expected), 32'(read));
    endtask

    // Strobe pattern set at each falling edge and model checked at the next one
    task automatic video_run(input int cycles, input logic random_char);
        logic char_now;
        int   i;
        @(negedge clock);
        for (i = 0; i < cycles; i++) begin
            char_now     = random_char ? ($urandom_range(3) != 0) : 1'b1;
            video_char_i = char_now;
            @(negedge clock);
            if (char_now) begin
                model_count = next_cell(model_count, model_col80);
            end
            check_value("video_addr_o", 32'(masked_address(model_count, model_mask)),
                        32'(video_addr_o));
        end
        video_char_i = 1'b0;
    endtask

    task automatic video_check();
        bus_write(REG_VIDEO, video_value(1'b0, 2'b11));
        video_run(SCREEN_ROWS * COLS_40, 1'b0);
        check_value("video_addr_o", 32'd0, 32'(video_addr_o));
        bus_write(REG_VIDEO, video_value(1'b1, 2'b01));
        video_run(5000, 1'b1);
        // Frame start wins over a character strobe
        @(negedge clock);
        video_frame_i = 1'b1;
        video_char_i  = 1'b1;
        @(negedge clock);
        video_frame_i = 1'b0;
        video_char_i  = 1'b0;
        model_count   = '0;
        check_value("video_addr_o", 32'd0, 32'(video_addr_o));
    endtask

    // Bound assertion failures and run length
    always @(negedge clock) begin
        cycle_count = cycle_count + 1;
        if (i_pet_system_ctrl.i_properties.failure_count != 0) begin
            $display("A bound assertion on the DUT failed");
            $display("Testbench failed");
            $fatal(1, "assertion failure");
        end else if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Testbench failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        void'($urandom(32'hf5666a53));
        cycle_count       = 0;
        wb_cyc_i          = 1'b0;
        wb_stb_i          = 1'b0;
        wb_we_i           = 1'b0;
        wb_adr_i          = '0;
        wb_dat_i          = '0;
        video_graphic_i   = 1'b0;
        config_crt_i      = 1'b0;
        config_keyboard_i = 1'b0;
        video_char_i      = 1'b0;
        video_frame_i     = 1'b0;
        model_count       = '0;
        model_col80       = 1'b0;
        model_mask        = 2'b11;
        @(posedge reset_n);
        power_on_check();
        register_check();
        reset_stretch_check();
        nmi_check();
        status_check(3'b001);
        status_check(3'b010);
        status_check(3'b100);
        video_check();
        @(negedge clock);
        if (i_pet_system_ctrl.i_properties.failure_count == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Testbench failed");
            $fatal(1, "assertion failure at end of run");
        end
    end

endmodule

`default_nettype wire

/* sim/pet_system_ctrl_properties.sv */
// Concurrent assertions on the Wishbone handshake and CPU control outputs, with their bind
`timescale 1ns/100ps
`default_nettype none

module pet_system_ctrl_properties (
    input wire clock,
    input wire reset_n,
    input wire wb_cyc_i,
    input wire wb_stb_i,
    input wire wb_ack_o,
    input wire wb_stall_o,
    input wire cpu_reset_o,
    input wire cpu_ready_o,
    input wire cpu_nmi_o
);

    // Failed assertions so far, watched by the testbench
    int unsigned failure_count = 0;

    // No back-pressure on the bus
    stall_low: assert property (@(posedge clock) disable iff (!reset_n) !wb_stall_o)
        else begin
            failure_count = failure_count + 1;
            $error("wb_stall_o went high");
        end

    // Every accepted strobe answered on the next edge
    ack_after_strobe: assert property (@(posedge clock) disable iff (!reset_n)
        (wb_cyc_i && wb_stb_i) |=> wb_ack_o)
        else begin
            failure_count = failure_count + 1;
            $error("no wb_ack_o one cycle after an accepted strobe");
        end

    // And no ack without a strobe one cycle before
    ack_only_after_strobe: assert property (@(posedge clock) disable iff (!reset_n)
        wb_ack_o |-> $past(wb_cyc_i && wb_stb_i))
        else begin
            failure_count = failure_count + 1;
            $error("wb_ack_o without an accepted strobe");
        end

    // Single cycle nmi
    nmi_single_cycle: assert property (@(posedge clock) disable iff (!reset_n)
        cpu_nmi_o |=> !cpu_nmi_o)
        else begin
            failure_count = failure_count + 1;
            $error("cpu_nmi_o high for two cycles in a row");
        end

    // Ready gated by the stretched reset
    ready_gated: assert property (@(posedge clock) disable iff (!reset_n)
        !(cpu_ready_o && cpu_reset_o))
        else begin
            failure_count = failure_count + 1;
            $error("cpu_ready_o high while cpu_reset_o high");
        end

endmodule

bind pet_system_ctrl pet_system_ctrl_properties i_properties (
    .clock       (clock),
    .reset_n     (reset_n),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_ack_o    (wb_ack_o),
    .wb_stall_o  (wb_stall_o),
    .cpu_reset_o (cpu_reset_o),
    .cpu_ready_o (cpu_ready_o),
    .cpu_nmi_o   (cpu_nmi_o)
);

`default_nettype wire

/* sim/clock_gen.sv */
// Testbench clock source and power-on reset generator
`timescale 1ns/100ps
`default_nettype none

module clock_gen (
    output logic clock_o,
    output logic reset_n_o
);

    // 8 ns period
    localparam realtime HALF_PERIOD = 4ns;
    localparam int      RESET_CYCLES = 4;

    initial begin
        clock_o = 1'b0;
        forever #(HALF_PERIOD) clock_o = ~clock_o;
    end

    // Released on a falling edge, clear of the rising edges
    initial begin
        reset_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock_o);
        @(negedge clock_o);
        reset_n_o = 1'b1;
    end

endmodule

`default_nettype wire

/* hw/pet_system_ctrl.sv */
// Top level joining the register file with the CPU control and video address blocks
`timescale 1ns/100ps
`default_nettype none

module pet_system_ctrl
    import bus_pkg::*;
    import pet_reg_pkg::*;
#(
    parameter int RESET_HOLD_CYCLES = 16
) (
    input  wire              clock,
    input  wire              reset_n,

    // Wishbone host port
    input  wire              wb_cyc_i,
    input  wire              wb_stb_i,
    input  wire              wb_we_i,
    input  wire wb_addr_t    wb_adr_i,
    input  wire wb_data_t    wb_dat_i,
    output wb_data_t         wb_dat_o,
    output logic             wb_ack_o,
    output logic             wb_stall_o,

    // Board status inputs
    input  wire              video_graphic_i,
    input  wire              config_crt_i,
    input  wire              config_keyboard_i,

    // CPU control lines
    output logic             cpu_reset_o,
    output logic             cpu_ready_o,
    output logic             cpu_nmi_o,

    // Video timing in, character address out
    input  wire              video_char_i,
    input  wire              video_frame_i,
    output video_addr_t      video_addr_o
);

    // Register bits
    logic       cpu_ready_bit;
    logic       cpu_reset_bit;
    logic       cpu_nmi_bit;
    logic       col80_mode;
    logic [1:0] ram_mask;

    register_file i_register_file (
        .clock             (clock),
        .reset_n           (reset_n),
        .wb_cyc_i          (wb_cyc_i),
        .wb_stb_i          (wb_stb_i),
        .wb_we_i           (wb_we_i),
        .wb_adr_i          (wb_adr_i),
        .wb_dat_i          (wb_dat_i),
        .wb_dat_o          (wb_dat_o),
        .wb_ack_o          (wb_ack_o),
        .wb_stall_o        (wb_stall_o),
        .video_graphic_i   (video_graphic_i),
        .config_crt_i      (config_crt_i),
        .config_keyboard_i (config_keyboard_i),
        .cpu_ready_bit_o   (cpu_ready_bit),
        .cpu_reset_bit_o   (cpu_reset_bit),
        .cpu_nmi_bit_o     (cpu_nmi_bit),
        .col80_mode_o      (col80_mode),
        .ram_mask_o        (ram_mask)
    );

    cpu_control #(
        .RESET_HOLD_CYCLES (RESET_HOLD_CYCLES)
    ) i_cpu_control (
        .clock           (clock),
        .reset_n         (reset_n),
        .cpu_ready_bit_i (cpu_ready_bit),
        .cpu_reset_bit_i (cpu_reset_bit),
        .cpu_nmi_bit_i   (cpu_nmi_bit),
        .cpu_reset_o     (cpu_reset_o),
        .cpu_ready_o     (cpu_ready_o),
        .cpu_nmi_o       (cpu_nmi_o)
    );

    video_address i_video_address (
        .clock         (clock),
        .reset_n       (reset_n),
        .col80_mode_i  (col80_mode),
        .ram_mask_i    (ram_mask),
        .video_char_i  (video_char_i),
        .video_frame_i (video_frame_i),
        .video_addr_o  (video_addr_o)
    );

endmodule

`default_nettype wire

/* hw/video_address.sv */
// Character cell address counter with 40/80 column mode and RAM mask
`timescale 1ns/100ps
`default_nettype none

module video_address
    import pet_reg_pkg::*;
(
    input  wire         clock,
    input  wire         reset_n,
    input  wire         col80_mode_i,
    input  wire  [1:0]  ram_mask_i,
    input  wire         video_char_i,
    input  wire         video_frame_i,
    output video_addr_t video_addr_o
);

    // Last cell of a full screen in each mode
    localparam video_addr_t LAST_CELL_40 = video_addr_t'(SCREEN_ROWS * COLS_40 - 1);
    localparam video_addr_t LAST_CELL_80 = video_addr_t'(SCREEN_ROWS * COLS_80 - 1);

    video_addr_t count_q;
    video_addr_t last_cell;
    logic        at_last;

    assign last_cell = col80_mode_i ? LAST_CELL_80 : LAST_CELL_40;

    // Also catches a count left past the end by a switch to 40 columns
    assign at_last = (count_q >= last_cell);

    // Cell counter
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            count_q <= '0;
        end else if (video_frame_i) begin
            // Frame start wins over a character strobe
            count_q <= '0;
        end else if (video_char_i) begin
            if (at_last) begin
                count_q <= '0;
            end else begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    // Mask the two top bits to select the video RAM window
    assign video_addr_o = {count_q[11:10] & ram_mask_i, count_q[9:0]};

endmodule

`default_nettype wire

/* hw/cpu_control.sv */
// CPU reset stretcher, ready gating and nmi pulse generator
`timescale 1ns/100ps
`default_nettype none

module cpu_control #(
    parameter int RESET_HOLD_CYCLES = 16
) (
    input  wire  clock,
    input  wire  reset_n,
    input  wire  cpu_ready_bit_i,
    input  wire  cpu_reset_bit_i,
    input  wire  cpu_nmi_bit_i,
    output logic cpu_reset_o,
    output logic cpu_ready_o,
    output logic cpu_nmi_o
);

    // First low cycle of the reset bit is spent in IN_RESET
    // HOLD covers the remaining RESET_HOLD_CYCLES - 1 cycles
    localparam int COUNT_WIDTH = (RESET_HOLD_CYCLES > 2) ? $clog2(RESET_HOLD_CYCLES) : 1;
    localparam int HOLD_LOAD   = (RESET_HOLD_CYCLES > 2) ? RESET_HOLD_CYCLES - 2 : 0;

    typedef enum logic [1:0] {
        IN_RESET,
        HOLD,
        RUN
    } cpu_state_t;

    cpu_state_t             state_q;
    logic [COUNT_WIDTH-1:0] hold_count_q;
    logic                   nmi_prev_q;

    // Reset release sequencing
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state_q      <= IN_RESET;
            hold_count_q <= '0;
        end else if (cpu_reset_bit_i) begin
            // Reset bit set again restarts the whole sequence
            state_q <= IN_RESET;
        end else begin
            case (state_q)
                IN_RESET: begin
                    if (RESET_HOLD_CYCLES > 1) begin
                        state_q      <= HOLD;
                        hold_count_q <= COUNT_WIDTH'(HOLD_LOAD);
                    end else begin
                        state_q <= RUN;
                    end
                end
                HOLD: begin
                    if (hold_count_q == '0) begin
                        state_q <= RUN;
                    end else begin
                        hold_count_q <= hold_count_q - 1'b1;
                    end
                end
                default: state_q <= RUN;
            endcase
        end
    end

    // High with the bit itself, then stretched until RUN
    assign cpu_reset_o = cpu_reset_bit_i | (state_q != RUN);

    // CPU never sees ready while held in reset
    assign cpu_ready_o = cpu_ready_bit_i & ~cpu_reset_o;

    // Previous nmi bit for edge detection
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            nmi_prev_q <= 1'b0;
        end else begin
            nmi_prev_q <= cpu_nmi_bit_i;
        end
    end

    // Single cycle pulse on a 0 to 1 change of the bit
    assign cpu_nmi_o = cpu_nmi_bit_i & ~nmi_prev_q;

endmodule

`default_nettype wire

/* hw/register_file.sv */
// Wishbone slave with the status, CPU control and video control registers
`timescale 1ns/100ps
`default_nettype none

module register_file
    import bus_pkg::*;
    import pet_reg_pkg::*;
(
    input  wire              clock,
    input  wire              reset_n,

    // Pipelined Wishbone slave
    input  wire              wb_cyc_i,
    input  wire              wb_stb_i,
    input  wire              wb_we_i,
    input  wire wb_addr_t    wb_adr_i,
    input  wire wb_data_t    wb_dat_i,
    output wb_data_t         wb_dat_o,
    output logic             wb_ack_o,
    output logic             wb_stall_o,

    // Board inputs for the status register
    input  wire              video_graphic_i,
    input  wire              config_crt_i,
    input  wire              config_keyboard_i,

    // CPU control bits
    output logic             cpu_ready_bit_o,
    output logic             cpu_reset_bit_o,
    output logic             cpu_nmi_bit_o,

    // Video control bits
    output logic             col80_mode_o,
    output logic [1:0]       ram_mask_o
);

    // Writable bits of each register, the rest read back as zero
    localparam wb_data_t CPU_DEFINED = wb_data_t'((1 << REG_CPU_READY_BIT)
                                                | (1 << REG_CPU_RESET_BIT)
                                                | (1 << REG_CPU_NMI_BIT));
    localparam wb_data_t VIDEO_DEFINED = wb_data_t'((1 << REG_VIDEO_COL80_BIT)
                                                  | (3 << REG_VIDEO_MASK_LSB));

    wb_data_t status_q;
    wb_data_t cpu_q;
    wb_data_t video_q;
    wb_data_t rd_data;
    logic     accept;
    logic     write_en;

    // Transfer taken on any edge with cycle and strobe high
    assign accept   = wb_cyc_i & wb_stb_i;
    assign write_en = accept & wb_we_i;

    // Register access never waits
    assign wb_stall_o = 1'b0;

    // Board inputs sampled every clock
    always_ff @(posedge clock) begin
        status_q                          <= '0;
        status_q[REG_STATUS_GRAPHICS_BIT] <= video_graphic_i;
        status_q[REG_STATUS_CRT_BIT]      <= config_crt_i;
        status_q[REG_STATUS_KEYBOARD_BIT] <= config_keyboard_i;
    end

    // Writable registers
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            cpu_q   <= REG_CPU_RESET_VALUE;
            video_q <= REG_VIDEO_RESET_VALUE;
        end else if (write_en) begin
            // Status slot and the spare slot drop writes
            if (wb_adr_i == REG_CPU) begin
                cpu_q <= wb_dat_i & CPU_DEFINED;
            end
            if (wb_adr_i == REG_VIDEO) begin
                video_q <= wb_dat_i & VIDEO_DEFINED;
            end
        end
    end

    // Read mux
    always_comb begin
        case (wb_adr_i)
            REG_STATUS: rd_data = status_q;
            REG_CPU:    rd_data = cpu_q;
            REG_VIDEO:  rd_data = video_q;
            // Spare slot
            default:    rd_data = '0;
        endcase
    end

    // Read data captured with the request, shown alongside ack
    always_ff @(posedge clock) begin
        if (accept && !wb_we_i) begin
            wb_dat_o <= rd_data;
        end
    end

    // One cycle response for every accepted strobe
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= accept;
        end
    end

    // Register bits out to the CPU and video blocks
    assign cpu_ready_bit_o = cpu_q[REG_CPU_READY_BIT];
    assign cpu_reset_bit_o = cpu_q[REG_CPU_RESET_BIT];
    assign cpu_nmi_bit_o   = cpu_q[REG_CPU_NMI_BIT];
    assign col80_mode_o    = video_q[REG_VIDEO_COL80_BIT];
    assign ram_mask_o      = video_q[REG_VIDEO_MASK_LSB +: 2];

endmodule

`default_nettype wire

/* hw/pet_reg_pkg.sv */
// Register map, bit positions, reset values and screen geometry of the control block
`default_nettype none

package pet_reg_pkg;
    import bus_pkg::*;

    // Register slots, address 3 reads zero and ignores writes
    localparam wb_addr_t REG_STATUS = 2'd0;
    localparam wb_addr_t REG_CPU    = 2'd1;
    localparam wb_addr_t REG_VIDEO  = 2'd2;

    // Status register, read only board inputs
    localparam int REG_STATUS_GRAPHICS_BIT = 0;
    localparam int REG_STATUS_CRT_BIT      = 1;
    localparam int REG_STATUS_KEYBOARD_BIT = 2;

    // CPU control register
    localparam int REG_CPU_READY_BIT = 0;
    localparam int REG_CPU_RESET_BIT = 1;
    localparam int REG_CPU_NMI_BIT   = 2;

    // Video control register, RAM mask sits in bits 3:2
    localparam int REG_VIDEO_COL80_BIT = 0;
    localparam int REG_VIDEO_MASK_LSB  = 2;

    // CPU held in reset and not ready at power on
    localparam wb_data_t REG_CPU_RESET_VALUE   = 8'h02;
    // 40 columns, both mask bits open
    localparam wb_data_t REG_VIDEO_RESET_VALUE = 8'h0C;

    // Character screen geometry
    localparam int SCREEN_ROWS = 25;
    localparam int COLS_40     = 40;
    localparam int COLS_80     = 80;

    // Video RAM character address
    localparam int VIDEO_ADDR_WIDTH = 12;
    typedef logic [VIDEO_ADDR_WIDTH-1:0] video_addr_t;

endpackage

`default_nettype wire

/* hw/bus_pkg.sv */
// Wishbone bus widths and address and data vector types
`default_nettype none

package bus_pkg;

    // Register slot address width
    // Four slots, the last one unused
    localparam int WB_ADDR_WIDTH = 2;

    // Byte wide data path
    localparam int WB_DATA_WIDTH = 8;

    // Register address as seen on wb_adr
    typedef logic [WB_ADDR_WIDTH-1:0] wb_addr_t;

    // Read and write data on wb_dat
    typedef logic [WB_DATA_WIDTH-1:0] wb_data_t;

endpackage

`default_nettype wire
